//--- testbench/io_stim.txt
// Word: op _ port _ data _ expected. Ops: 1 write, 2 read (data = mask), 3 push mouse byte,
// 4 mouse_ready level, 5 irq4 level, 6 hold mouse byte, 7 LED frame check, F end
7_000_00_00
2_061_FF_00
1_061_A5_00
2_061_FF_A5
2_123_FF_FF
2_3DA_F6_00
1_3F9_5A_00
1_3FA_C3_00
1_3FB_81_00
1_3FE_3C_00
1_3FF_E7_00
2_3F9_FF_5A
2_3FA_FF_C3
2_3FB_FF_81
2_3FE_FF_3C
2_3FF_FF_E7
1_3FD_A5_00
2_3FD_FF_A4
5_000_00_00
3_000_11_00
3_000_22_00
3_000_33_00
3_000_44_00
3_000_55_00
3_000_66_00
5_000_00_01
2_3FD_FF_A5
4_000_00_00
6_000_77_00
4_000_00_00
2_3F8_FF_11
2_3F8_FF_22
2_3F8_FF_33
2_3F8_FF_44
2_3F8_FF_55
2_3F8_FF_66
2_3F8_FF_77
5_000_00_00
2_3F8_FF_00
5_000_00_00
4_000_00_01
1_3FC_0B_00
2_3FC_FF_0B
5_000_00_01
2_3F8_FF_4D
2_3F8_FF_4D
2_3F8_FF_4D
2_3F8_FF_4D
2_3F8_FF_4D
2_3F8_FF_4D
2_3F8_FF_00
5_000_00_00
1_080_3C_00
7_000_00_00
1_080_96_00
7_000_00_00
F_000_00_00

//--- files.f
design/io_map_pkg.sv
design/io_types_pkg.sv
design/io_bus_ctrl.sv
design/com1_mouse.sv
design/system_ports.sv
design/led_shifter.sv
design/io_top.sv
testbench/tb_io_top.sv

//--- Bender.yml
package:
  name: io_top

sources:
  # Design, packages first
  - files:
      - design/io_map_pkg.sv
      - design/io_types_pkg.sv
      - design/io_bus_ctrl.sv
      - design/com1_mouse.sv
      - design/system_ports.sv
      - design/led_shifter.sv
      - design/io_top.sv
  # Testbench
  - target: test
    files:
      - testbench/tb_io_top.sv

//--- testbench/tb_io_top.sv
`default_nettype none

module tb_io_top;
	timeunit 1ns;
	timeprecision 1ps;

	import io_types_pkg::*;
	import io_map_pkg::*;

	localparam integer STIM_LEN   = 64;
	localparam integer WAIT_LIMIT = 100;

	logic     clk;
	logic     rst;
	logic     req_valid;
	io_req_t  req;
	logic     req_ready;
	logic     rsp_valid;
	io_rsp_t  rsp;
	logic     rsp_ready;
	logic     mouse_valid;
	io_data_t mouse_byte;
	logic     mouse_ready;
	logic     irq4;
	logic     clk595;
	logic     dat595;
	logic     lat595;

	// Step word fields op[31:28], port[27:16], data[15:8] and expected[7:0]
	logic [31:0] stim [STIM_LEN];
	logic [31:0] lcg_state;
	int          errors;
	int          steps;
	int          failed_steps;
	int          errors_before;
	int          idx;
	int          base;
	int          count;
	logic        done;
	logic        timed_out;
	logic [3:0]  op;
	io_port_t    port;
	io_data_t    data;
	io_data_t    expected;
	io_data_t    rd;
	io_data_t    post_last;
	string       name;

	// LED monitor state
	io_data_t led_shift;
	io_data_t led_byte;
	int       led_bits;
	int       led_frames;

	io_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req         (req),
		.req_ready   (req_ready),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp),
		.rsp_ready   (rsp_ready),
		.mouse_valid (mouse_valid),
		.mouse_byte  (mouse_byte),
		.mouse_ready (mouse_ready),
		.irq4        (irq4),
		.clk595      (clk595),
		.dat595      (dat595),
		.lat595      (lat595)
	);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:16];
	endfunction

	task automatic check_data(input string label, input io_data_t exp_val, input io_data_t act);
		if (act !== exp_val)
		begin
			errors++;
			$display("ERROR %s: expected 0x%02h, actual 0x%02h", label, exp_val, act);
		end
	endtask

	task automatic check_bit(input string label, input logic exp_val, input logic act);
		if (act !== exp_val)
		begin
			errors++;
			$display("ERROR %s: expected %b, actual %b", label, exp_val, act);
		end
	endtask

	// Marks a wait that ran out so that playback stops
	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("TIMEOUT: %s", what);
	endtask

	// Advance to the next falling edge and retire a mouse byte taken in between
	task automatic next_cycle();
		logic taken;
		taken = mouse_valid && mouse_ready;
		@(negedge clk);
		if (taken)
			mouse_valid = 1'b0;
	endtask

	// One full request/response transaction with random response stalls
	task automatic bus_xfer(input logic is_write, input io_port_t addr, input io_data_t wbyte,
			input string label, output io_data_t rbyte);
		int       waited;
		int       stall;
		io_data_t held;
		rbyte     = 8'h00;
		req.port  = addr;
		req.write = is_write;
		req.wdata = wbyte;
		req_valid = 1'b1;
		rsp_ready = 1'b0;
		waited    = 0;
		while (!req_ready && !timed_out)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout($sformatf("%s: req_ready never rose", label));
		end
		if (!timed_out)
		begin
			// Taken on the coming edge
			next_cycle();
		end
		req_valid = 1'b0;
		waited    = 0;
		while (!rsp_valid && !timed_out)
		begin
			check_bit($sformatf("%s req_ready while busy", label), 1'b0, req_ready);
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout($sformatf("%s: no response arrived", label));
		end
		if (!timed_out)
		begin
			held  = rsp.rdata;
			stall = next_rand() % 4;
			// Response must sit still while rsp_ready is low
			repeat (stall)
			begin
				next_cycle();
				check_bit($sformatf("%s rsp_valid held", label), 1'b1, rsp_valid);
				check_data($sformatf("%s rsp held", label), held, rsp.rdata);
				check_bit($sformatf("%s req_ready while held", label), 1'b0, req_ready);
			end
			rsp_ready = 1'b1;
			next_cycle();
			rsp_ready = 1'b0;
			if (is_write && addr == PORT_POST)
				post_last = wbyte;
			rbyte = held;
		end
	endtask

	task automatic push_mouse(input io_data_t b, input string label);
		int waited;
		waited = 0;
		// An earlier held byte goes first
		while (mouse_valid && !timed_out)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout($sformatf("%s: earlier mouse byte was never taken", label));
		end
		if (!timed_out)
		begin
			mouse_byte  = b;
			mouse_valid = 1'b1;
		end
		waited = 0;
		while (mouse_valid && !timed_out)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout($sformatf("%s: mouse_ready never rose", label));
		end
	endtask

	//////////////////////////////////////////////////
	// LED capture
	//////////////////////////////////////////////////

	// clk595 and lat595 are one cycle pulses seen at the falling edge
	always @(negedge clk)
	begin
		if (rst)
		begin
			led_bits   <= 0;
			led_frames <= 0;
		end
		else
		begin
			if (clk595)
			begin
				led_shift <= {led_shift[6:0], dat595};
				led_bits  <= led_bits + 1;
			end
			if (lat595)
			begin
				if (led_bits != 8)
				begin
					errors++;
					$display("LED frame latched after %0d clock pulses instead of 8", led_bits);
				end
				led_byte   <= led_shift;
				led_frames <= led_frames + 1;
				led_bits   <= 0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus playback
	//////////////////////////////////////////////////

	initial
	begin
		rst          = 1'b1;
		req_valid    = 1'b0;
		req          = '0;
		rsp_ready    = 1'b0;
		mouse_valid  = 1'b0;
		mouse_byte   = '0;
		lcg_state    = 32'd65;
		errors       = 0;
		steps        = 0;
		failed_steps = 0;
		post_last    = 8'h00;
		done         = 1'b0;
		timed_out    = 1'b0;
		$readmemh("testbench/io_stim.txt", stim);

		repeat (8) @(negedge clk);
		rst = 1'b0;

		// Idle state right after reset
		errors_before = errors;
		check_bit("reset req_ready", 1'b1, req_ready);
		check_bit("reset rsp_valid", 1'b0, rsp_valid);
		check_bit("reset irq4", 1'b0, irq4);
		check_bit("reset mouse_ready", 1'b1, mouse_ready);
		check_bit("reset clk595", 1'b0, clk595);
		check_bit("reset lat595", 1'b0, lat595);
		steps++;
		if (errors == errors_before)
			$display("reset state: passed");
		else
		begin
			failed_steps++;
			$display("reset state: failed");
		end

		for (idx = 0; idx < STIM_LEN && !done; idx++)
		begin
			op            = stim[idx][31:28];
			port          = stim[idx][27:16];
			data          = stim[idx][15:8];
			expected      = stim[idx][7:0];
			errors_before = errors;
			case (op)
				4'h1:
				begin
					name = $sformatf("step %0d write 0x%03h", idx, port);
					bus_xfer(1'b1, port, data, name, rd);
					// Writes answer with zero
					if (!timed_out)
						check_data(name, 8'h00, rd);
				end
				4'h2:
				begin
					// Data column is the compare mask
					name = $sformatf("step %0d read 0x%03h", idx, port);
					bus_xfer(1'b0, port, 8'h00, name, rd);
					if (!timed_out)
						check_data(name, expected, rd & data);
				end
				4'h3:
				begin
					name = $sformatf("step %0d push 0x%02h", idx, data);
					push_mouse(data, name);
				end
				4'h4:
				begin
					name = $sformatf("step %0d mouse_ready", idx);
					check_bit(name, expected[0], mouse_ready);
				end
				4'h5:
				begin
					// irq4 trails the queue by a cycle
					name = $sformatf("step %0d irq4", idx);
					next_cycle();
					check_bit(name, expected[0], irq4);
				end
				4'h6:
				begin
					// Offered now and taken once the queue has room
					name        = $sformatf("step %0d hold 0x%02h", idx, data);
					mouse_byte  = data;
					mouse_valid = 1'b1;
				end
				4'h7:
				begin
					// Second latch is sure to carry the latest POST code
					name  = $sformatf("step %0d LED frame", idx);
					base  = led_frames;
					count = 0;
					while (led_frames < base + 2 && !timed_out)
					begin
						next_cycle();
						count++;
						if (count > WAIT_LIMIT)
							report_timeout($sformatf("%s: no lat595 pulse", name));
					end
					if (!timed_out)
						check_data(name, ~post_last, led_byte);
				end
				4'hF:
					done = 1'b1;
				default:
				begin
					name = $sformatf("step %0d", idx);
					errors++;
					$display("Unknown operation code %h at step %0d, playback stops", op, idx);
					done = 1'b1;
				end
			endcase
			if (timed_out)
				done = 1'b1;
			if (op != 4'hF)
			begin
				steps++;
				if (errors == errors_before)
					$display("%s: passed", name);
				else
				begin
					failed_steps++;
					$display("%s: failed", name);
				end
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			steps, steps - failed_steps, failed_steps, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/io_top.sv
`default_nettype none

module io_top (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         req_valid,
	input  wire io_types_pkg::io_req_t  req,
	output logic                        req_ready,
	output logic                        rsp_valid,
	output io_types_pkg::io_rsp_t       rsp,
	input  wire                         rsp_ready,
	input  wire                         mouse_valid,
	input  wire io_types_pkg::io_data_t mouse_byte,
	output logic                        mouse_ready,
	output logic                        irq4,
	output logic                        clk595,
	output logic                        dat595,
	output logic                        lat595
);
	import io_types_pkg::*;

	port_strobe_t strobe;
	io_data_t     com1_rdata;
	io_data_t     keyb_ctrl;
	io_data_t     vga_status;
	io_data_t     post_code;

	//////////////////////////////////////////////////
	// Bus controller
	//////////////////////////////////////////////////

	io_bus_ctrl bus_ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_ready  (rsp_ready),
		.strobe     (strobe),
		.com1_rdata (com1_rdata),
		.keyb_ctrl  (keyb_ctrl),
		.vga_status (vga_status),
		.post_code  (post_code)
	);

	//////////////////////////////////////////////////
	// Targets
	//////////////////////////////////////////////////

	// Serial mouse on COM1
	com1_mouse com1_i (
		.clk         (clk),
		.rst         (rst),
		.strobe      (strobe),
		.com1_rdata  (com1_rdata),
		.mouse_valid (mouse_valid),
		.mouse_byte  (mouse_byte),
		.mouse_ready (mouse_ready),
		.irq4        (irq4)
	);

	system_ports sys_i (
		.clk        (clk),
		.rst        (rst),
		.strobe     (strobe),
		.keyb_ctrl  (keyb_ctrl),
		.vga_status (vga_status),
		.post_code  (post_code)
	);

	// POST code out to the 595 LED chain
	led_shifter led_i (
		.clk       (clk),
		.rst       (rst),
		.post_code (post_code),
		.clk595    (clk595),
		.dat595    (dat595),
		.lat595    (lat595)
	);

endmodule

`default_nettype wire

//--- design/led_shifter.sv
`default_nettype none

module led_shifter (
	input  wire                         clk,
	input  wire                         rst,
	input  wire io_types_pkg::io_data_t post_code,
	output logic                        clk595,
	output logic                        dat595,
	output logic                        lat595
);
	import io_types_pkg::*;
	import io_map_pkg::*;

	// One hot frame position
	logic [LED_FRAME_STEPS - 1:0] step;
	io_data_t                     shift_q;
	logic                         pulse;

	// Odd steps 1..15 give the eight clock pulses
	always_comb
	begin
		pulse = 1'b0;
		for (int i = 1; i < LED_FRAME_STEPS - 1; i += 2)
			pulse = pulse | step[i];
	end

	// MSB first
	assign dat595 = shift_q[7];

	//////////////////////////////////////////////////
	// Frame sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			step   <= {{(LED_FRAME_STEPS - 1){1'b0}}, 1'b1};
			clk595 <= 1'b0;
			lat595 <= 1'b0;
		end
		else
		begin
			step   <= {step[LED_FRAME_STEPS - 2:0], step[LED_FRAME_STEPS - 1]};
			clk595 <= pulse;
			// Latch right after the last bit
			lat595 <= step[LED_FRAME_STEPS - 1];
		end
	end

	// Shift one cycle after each rising clk595
	always_ff @(posedge clk)
	begin
		if (step[0])
			// LEDs are active low
			shift_q <= ~post_code;
		else if (clk595)
			shift_q <= {shift_q[6:0], 1'b0};
	end

endmodule

`default_nettype wire

//--- design/system_ports.sv
`default_nettype none

module system_ports (
	input  wire                             clk,
	input  wire                             rst,
	input  wire io_types_pkg::port_strobe_t strobe,
	output io_types_pkg::io_data_t          keyb_ctrl,
	output io_types_pkg::io_data_t          vga_status,
	output io_types_pkg::io_data_t          post_code
);
	import io_map_pkg::*;

	// Free running with only two taps in use
	logic [DIV_WIDTH - 1:0] div;

	//////////////////////////////////////////////////
	// Port 0x061, port 0x080 and the divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			keyb_ctrl <= 8'h00;
			post_code <= 8'h00;
			div       <= '0;
		end
		else
		begin
			div <= div + 1'b1;

			// Plain read back register
			if (strobe.keyb_wr)
				keyb_ctrl <= strobe.wdata;

			// Last POST code for the LEDs
			if (strobe.post_wr)
				post_code <= strobe.wdata;
		end
	end

	// Bit 3 vertical retrace, bit 0 display enable
	assign vga_status = {4'h0, div[DIV_TAP_RETRACE], 2'b00, div[DIV_TAP_ENABLE]};

endmodule

`default_nettype wire

//--- design/com1_mouse.sv
`default_nettype none

module com1_mouse (
	input  wire                             clk,
	input  wire                             rst,
	input  wire io_types_pkg::port_strobe_t strobe,
	output io_types_pkg::io_data_t          com1_rdata,
	input  wire                             mouse_valid,
	input  wire io_types_pkg::io_data_t     mouse_byte,
	output logic                            mouse_ready,
	output logic                            irq4
);
	import io_types_pkg::*;
	import io_map_pkg::*;

	// Queue fill level from 0 up to the depth
	typedef logic [$clog2(MOUSE_QUEUE_DEPTH + 1) - 1:0] fill_t;

	// Head of the queue sits in entry 0
	io_data_t queue [MOUSE_QUEUE_DEPTH];
	fill_t    fill;
	// Offsets 1..7 as offset 0 is the data port
	io_data_t regs [1:7];
	logic     not_empty;
	logic     pop;
	logic     reload;
	logic     push;

	assign not_empty = (fill != '0);
	assign pop       = strobe.com1_rd && (strobe.com1_ofs == COM1_OFS_DATA);
	assign reload    = strobe.com1_wr && (strobe.com1_ofs == COM1_OFS_MCR);

	// CPU access wins over the mouse stream
	assign mouse_ready = (fill != fill_t'(MOUSE_QUEUE_DEPTH)) && !pop && !reload;
	assign push        = mouse_valid && mouse_ready;

	//////////////////////////////////////////////////
	// Receive queue storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reload)
		begin
			// Driver probe gets ident bytes back
			for (int i = 0; i < MOUSE_QUEUE_DEPTH; i++)
				queue[i] <= MOUSE_ID_BYTE;
		end
		else if (push)
			queue[fill] <= mouse_byte;
		else if (pop)
		begin
			// Shift towards the head
			for (int i = 0; i < MOUSE_QUEUE_DEPTH - 1; i++)
				queue[i] <= queue[i + 1];
		end
	end

	//////////////////////////////////////////////////
	// Fill level, registers and interrupt
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fill <= '0;
			irq4 <= 1'b0;
			for (int i = 1; i <= 7; i++)
				regs[i] <= '0;
		end
		else
		begin
			// Follows the queue a cycle late
			irq4 <= not_empty;

			if (reload)
				fill <= fill_t'(MOUSE_QUEUE_DEPTH);
			else if (push)
				fill <= fill + fill_t'(1);
			else if (pop && not_empty)
				fill <= fill - fill_t'(1);

			// Data port writes go nowhere without a transmitter
			if (strobe.com1_wr && (strobe.com1_ofs != COM1_OFS_DATA))
				regs[strobe.com1_ofs] <= strobe.wdata;
		end
	end

	// Read mux showing the head before the pop
	always_comb
	begin
		case (strobe.com1_ofs)
			COM1_OFS_DATA:
				com1_rdata = not_empty ? queue[0] : 8'h00;
			COM1_OFS_LSR:
				// Bit 0 is data ready
				com1_rdata = {regs[COM1_OFS_LSR][7:1], not_empty};
			default:
				com1_rdata = regs[strobe.com1_ofs];
		endcase
	end

endmodule

`default_nettype wire

//--- design/io_bus_ctrl.sv
`default_nettype none

module io_bus_ctrl (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         req_valid,
	input  wire io_types_pkg::io_req_t  req,
	output logic                        req_ready,
	output logic                        rsp_valid,
	output io_types_pkg::io_rsp_t       rsp,
	input  wire                         rsp_ready,
	output io_types_pkg::port_strobe_t  strobe,
	input  wire io_types_pkg::io_data_t com1_rdata,
	input  wire io_types_pkg::io_data_t keyb_ctrl,
	input  wire io_types_pkg::io_data_t vga_status,
	input  wire io_types_pkg::io_data_t post_code
);
	import io_types_pkg::*;
	import io_map_pkg::*;

	bus_state_t state;
	io_req_t    req_q;
	logic       access;
	logic       hit_com1;
	logic       hit_keyb;
	logic       hit_post;
	logic       hit_vga;
	io_data_t   rd_sel;

	// One transaction in flight
	assign req_ready = (state == BUS_IDLE);
	assign rsp_valid = (state == BUS_RESPOND);
	assign access    = (state == BUS_ACCESS);

	//////////////////////////////////////////////////
	// Decode of the registered port
	//////////////////////////////////////////////////

	always_comb
	begin
		// COM1 matches on the upper nine bits
		hit_com1 = (req_q.port[11:3] == PORT_COM1_BASE[11:3]);
		hit_keyb = (req_q.port == PORT_KEYB_CTRL);
		hit_post = (req_q.port == PORT_POST);
		hit_vga  = (req_q.port == PORT_VGA_STATUS);
	end

	// Read data of the decoded target
	always_comb
	begin
		if (hit_com1)
			rd_sel = com1_rdata;
		else if (hit_keyb)
			rd_sel = keyb_ctrl;
		else if (hit_post)
			rd_sel = post_code;
		else if (hit_vga)
			rd_sel = vga_status;
		else
			rd_sel = UNMAPPED_READ;
	end

	// Strobes live only in the access cycle
	always_comb
	begin
		strobe.com1_wr  = access && req_q.write && hit_com1;
		strobe.com1_rd  = access && !req_q.write && hit_com1;
		strobe.com1_ofs = com1_ofs_t'(req_q.port[2:0]);
		strobe.keyb_wr  = access && req_q.write && hit_keyb;
		strobe.post_wr  = access && req_q.write && hit_post;
		strobe.wdata    = req_q.wdata;
	end

	//////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= BUS_IDLE;
		else
		begin
			case (state)
				BUS_IDLE:
					if (req_valid)
						state <= BUS_ACCESS;
				BUS_ACCESS:
					state <= BUS_RESPOND;
				BUS_RESPOND:
					// Hold the response until taken
					if (rsp_ready)
						state <= BUS_IDLE;
				default:
					state <= BUS_IDLE;
			endcase
		end
	end

	// Request capture and read data sample
	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
			req_q <= req;
		if (access)
			rsp.rdata <= req_q.write ? 8'h00 : rd_sel;
	end

endmodule

`default_nettype wire

//--- design/io_types_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Bus types shared by controller and targets
//////////////////////////////////////////////////

package io_types_pkg;

	typedef logic [7:0]  io_data_t;
	typedef logic [11:0] io_port_t;
	typedef logic [2:0]  com1_ofs_t;

	// CPU side request
	typedef struct packed {
		io_port_t port;
		logic     write;
		io_data_t wdata;
	} io_req_t;

	// Read data that is zero for writes
	typedef struct packed {
		io_data_t rdata;
	} io_rsp_t;

	// Single cycle target strobes
	typedef struct packed {
		logic      com1_wr;
		logic      com1_rd;
		com1_ofs_t com1_ofs;
		logic      keyb_wr;
		logic      post_wr;
		io_data_t  wdata;
	} port_strobe_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_ACCESS,
		BUS_RESPOND
	} bus_state_t;

endpackage

`default_nettype wire

//--- design/io_map_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// I/O port map of the system
//////////////////////////////////////////////////

package io_map_pkg;

	// Fixed ports
	localparam logic [11:0] PORT_KEYB_CTRL  = 12'h061;
	localparam logic [11:0] PORT_POST       = 12'h080;
	localparam logic [11:0] PORT_VGA_STATUS = 12'h3DA;

	// COM1 occupies 0x3F8..0x3FF
	localparam logic [11:0] PORT_COM1_BASE = 12'h3F8;

	// Register offsets inside the COM1 block
	localparam logic [2:0] COM1_OFS_DATA = 3'd0;
	localparam logic [2:0] COM1_OFS_MCR  = 3'd4;
	localparam logic [2:0] COM1_OFS_LSR  = 3'd5;

	// Serial mouse receive queue
	localparam integer     MOUSE_QUEUE_DEPTH = 6;
	// Ident byte "M" of a serial mouse
	localparam logic [7:0] MOUSE_ID_BYTE     = 8'h4D;

	// Floating bus value
	localparam logic [7:0] UNMAPPED_READ = 8'hFF;

	// Display status divider and its taps
	localparam integer DIV_WIDTH       = 21;
	localparam integer DIV_TAP_ENABLE  = 13;
	localparam integer DIV_TAP_RETRACE = 20;

	// One 595 frame of load, 8 pulses with gaps and latch
	localparam integer LED_FRAME_STEPS = 17;

endpackage

`default_nettype wire
